/* tb.f */
hw/calc_pkg.sv
hw/key_decoder.sv
hw/calc_datapath.sv
hw/bin_to_bcd.sv
hw/result_line.sv
hw/lcd_controller.sv
hw/calc_top.sv
sim/calc_tb_checks.sv
sim/calc_tb.sv

/* sim/calc_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module calc_tb import calc_pkg::*; ();

    logic                    rst;
    logic                    clk_100hz;
    logic [digit_keys_w-1:0] swp;
    logic [op_keys_w-1:0]    swd;
    logic                    lcd_e;
    logic                    lcd_rs;
    logic                    lcd_rw;
    logic [7:0]              lcd_data;
    logic [8*line_len-1:0]   line_text;
    int                      addr_count;
    int                      line_count;
    logic                    fault;

    // reference model state
    logic [value_w-1:0]      m_acc;
    logic [value_w-1:0]      m_term;
    op_t                     m_pend;

    calc_top calc_top_inst (
        .rst       (rst),
        .clk_100hz (clk_100hz),
        .swp       (swp),
        .swd       (swd),
        .lcd_e     (lcd_e),
        .lcd_rs    (lcd_rs),
        .lcd_rw    (lcd_rw),
        .lcd_data  (lcd_data)
    );

    calc_tb_checks calc_tb_checks_inst (
        .rst        (rst),
        .clk_100hz  (clk_100hz),
        .lcd_e      (lcd_e),
        .lcd_rs     (lcd_rs),
        .lcd_rw     (lcd_rw),
        .lcd_data   (lcd_data),
        .line_text  (line_text),
        .addr_count (addr_count),
        .line_count (line_count),
        .fault      (fault)
    );

    initial
    begin
        rst = 1'b0;
        forever #2 rst = ~rst;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    a_monitor_clean: assert property (@(negedge rst) disable iff (clk_100hz) !fault)
    else
        fail_run("LCD bus monitor found a protocol error");

    // right aligned decimal digits with the sign to their left on a blank line
    function automatic logic [8*line_len-1:0] expected_line(input logic [value_w-1:0] value);
        logic [value_w-1:0]    mag;
        logic [8*line_len-1:0] text;
        int                    col;
        mag  = value[value_w-1] ? -value : value;
        text = {line_len{ascii_blank}};
        col  = line_len - 1;
        do
        begin
            text[8*(line_len-1-col) +: 8] = ascii_0 + 8'(mag % 10);
            mag = mag / 10;
            col--;
        end
        while (mag != 0);
        if (value[value_w-1])
            text[8*(line_len-1-col) +: 8] = ascii_minus;
        return text;
    endfunction

    function automatic logic [digit_keys_w-1:0] pad_of(input int d);
        logic [digit_keys_w-1:0] pad;
        pad = '0;
        pad[digit_key_bit[d]] = 1'b1;
        return pad;
    endfunction

    function automatic void apply_digit(input int d);
        m_term = m_term * 32'd10 + 32'(d);
    endfunction

    function automatic void apply_op(input op_t code);
        case (m_pend)
            op_sub:  m_acc = m_acc - m_term;
            op_mul:  m_acc = m_acc * m_term;
            default: m_acc = m_acc + m_term;
        endcase
        m_term = '0;
        m_pend = (code == op_equ) ? op_add : code;
    endfunction

    task automatic drive_keys(input logic [digit_keys_w-1:0] pad,
                              input logic [op_keys_w-1:0] ops, input int hold);
        @(posedge rst);
        #1;
        swp = pad;
        swd = ops;
        repeat (hold) @(posedge rst);
        #1;
        swp = '0;
        swd = '0;
        repeat (6) @(posedge rst);
    endtask

    task automatic press_digit(input int d, input int hold);
        drive_keys(pad_of(d), '0, hold);
        apply_digit(d);
    endtask

    task automatic press_op(input op_t code);
        logic [op_keys_w-1:0] ops;
        ops = '0;
        case (code)
            op_add:  ops[op_bit_add] = 1'b1;
            op_sub:  ops[op_bit_sub] = 1'b1;
            op_mul:  ops[op_bit_mul] = 1'b1;
            default: ops[op_bit_equ] = 1'b1;
        endcase
        drive_keys('0, ops, 6);
        apply_op(code);
    endtask

    task automatic enter_number(input logic [value_w-1:0] n);
        string s;
        s = $sformatf("%0d", n);
        for (int i = 0; i < s.len(); i++)
            press_digit(int'(s[i]) - int'(ascii_0), 6);
    endtask

    task automatic wait_lines(input int target);
        int waited;
        waited = 0;
        while (line_count < target)
        begin
            @(negedge rst);
            waited++;
            if (waited > 1000)
                fail_run("Timeout waiting for a complete line-2 refresh on the LCD");
        end
    endtask

    task automatic equals_and_check();
        logic [8*line_len-1:0] want;
        press_op(op_equ);
        want = expected_line(m_acc);
        // conversion ends about 37 cycles after the equals press
        repeat (30) @(posedge rst);
        @(negedge rst);
        wait_lines(addr_count + 1);
        a_result_line: assert (line_text == want)
        else
            fail_run($sformatf("Error at %0t: line_text is \"%s\", expected \"%s\"",
                               $time, line_text, want));
    endtask

    initial
    begin
        logic [value_w-1:0]   n;
        int                   sel;
        logic [op_keys_w-1:0] ops;
        void'($urandom(32'h97b3283a));
        clk_100hz = 1'b1;
        swp       = '0;
        swd       = '0;
        m_acc     = '0;
        m_term    = '0;
        m_pend    = op_add;
        repeat (5) @(posedge rst);
        #1;
        clk_100hz = 1'b0;

        // first burst after power-up is blank
        wait_lines(1);
        @(negedge rst);
        a_blank_line: assert (line_text == {line_len{ascii_blank}})
        else
            fail_run($sformatf("Error at %0t: line_text is \"%s\", expected a blank line",
                               $time, line_text));

        enter_number(1207);
        equals_and_check();

        // chain continues from the previous result
        press_op(op_add);
        enter_number(25);
        press_op(op_sub);
        enter_number(300);
        press_op(op_mul);
        enter_number(7);
        equals_and_check();

        for (int r = 0; r < 5; r++)
        begin
            for (int k = 0; k < 3; k++)
            begin
                sel = $urandom % 3;
                press_op(sel == 0 ? op_add : (sel == 1 ? op_sub : op_mul));
                n = (r == 4) ? $urandom : $urandom % 100000;
                enter_number(n);
            end
            equals_and_check();
        end

        // clear to zero, then negative results
        press_op(op_mul);
        enter_number(0);
        equals_and_check();
        press_op(op_mul);
        enter_number(0);
        press_op(op_sub);
        enter_number(42);
        equals_and_check();
        press_op(op_mul);
        enter_number(0);
        press_op(op_sub);
        enter_number(32'd2147483648);
        equals_and_check();

        // held key, chords, digit beats operator, unused switch bits
        press_op(op_mul);
        enter_number(0);
        press_op(op_add);
        press_digit(7, 40);
        drive_keys(pad_of(3) | pad_of(4), '0, 6);
        ops = '0;
        ops[op_bit_add] = 1'b1;
        drive_keys(pad_of(5), ops, 6);
        apply_digit(5);
        ops[op_bit_sub] = 1'b1;
        drive_keys('0, ops, 6);
        drive_keys(12'h004, '0, 6);
        drive_keys('0, 8'h08, 6);
        // a stray operator above would split the term here
        press_digit(2, 6);
        equals_and_check();

        if (fault)
            fail_run("LCD bus monitor found a protocol error");
        else
        begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sim/calc_tb_checks.sv */
`timescale 1ns/100ps
`default_nettype none

module calc_tb_checks import calc_pkg::*; (
    input  logic                  rst,
    input  logic                  clk_100hz,
    input  logic                  lcd_e,
    input  logic                  lcd_rs,
    input  logic                  lcd_rw,
    input  logic [7:0]            lcd_data,
    output logic [8*line_len-1:0] line_text,
    output int                    addr_count,
    output int                    line_count,
    output logic                  fault
);

    int         wr_idx;
    int         col;
    logic       wrote;
    logic       seq_fault;
    logic       bus_fault;
    logic       want_rs;
    logic [7:0] want_data;

    initial bus_fault = 1'b0;

    // init commands, then the line address and a blank first line
    always_comb
    begin
        want_rs   = 1'b0;
        want_data = ascii_blank;
        case (wr_idx)
            0:       want_data = cmd_function_set;
            1:       want_data = cmd_display_on;
            2:       want_data = cmd_entry_mode;
            3:       want_data = cmd_line2_addr;
            default: want_rs = 1'b1;
        endcase
    end

    always @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            wr_idx     <= 0;
            col        <= line_len;
            wrote      <= 1'b0;
            seq_fault  <= 1'b0;
            addr_count <= 0;
            line_count <= 0;
            line_text  <= '0;
        end
        else if (lcd_e)
        begin
            wr_idx <= wr_idx + 1;
            wrote  <= 1'b1;
            if (wr_idx < 4 + line_len)
            begin
                a_power_up: assert (lcd_rs == want_rs && lcd_data == want_data)
                else
                begin
                    $display("Error at %0t: lcd_rs/lcd_data of write %0d is %b/%h, expected %b/%h",
                             $time, wr_idx, lcd_rs, lcd_data, want_rs, want_data);
                    seq_fault <= 1'b1;
                end
            end
            if (!lcd_rs && lcd_data == cmd_line2_addr)
            begin
                addr_count <= addr_count + 1;
                col        <= 0;
            end
            else if (lcd_rs)
            begin
                a_char_in_burst: assert (col < line_len)
                else
                begin
                    $display("LCD character write at %0t does not follow a line address", $time);
                    seq_fault <= 1'b1;
                end
                // column 0 sits in the top byte
                line_text[8*(line_len-1-col) +: 8] <= lcd_data;
                col <= col + 1;
                if (col == line_len - 1)
                    line_count <= line_count + 1;
            end
        end
    end

    a_e_pulse: assert property (@(posedge rst) disable iff (clk_100hz)
        lcd_e |=> !lcd_e)
    else
    begin
        $display("lcd_e stayed high for more than one cycle at %0t", $time);
        bus_fault = 1'b1;
    end

    a_bus_stable: assert property (@(posedge rst) disable iff (clk_100hz)
        lcd_e |-> $stable({lcd_rs, lcd_data}) ##1 $stable({lcd_rs, lcd_data}))
    else
    begin
        $display("LCD bus changed around an enable pulse at %0t", $time);
        bus_fault = 1'b1;
    end

    a_rw_low: assert property (@(posedge rst) disable iff (clk_100hz)
        (wrote || lcd_e) |-> !lcd_rw)
    else
    begin
        $display("lcd_rw went high after the first write at %0t", $time);
        bus_fault = 1'b1;
    end

    assign fault = seq_fault | bus_fault;

endmodule

`default_nettype wire

/* hw/calc_top.sv */
`timescale 1ns/100ps
`default_nettype none

module calc_top import calc_pkg::*; (
    input  logic                    rst,
    input  logic                    clk_100hz,
    input  logic [digit_keys_w-1:0] swp,
    input  logic [op_keys_w-1:0]    swd,
    output logic                    lcd_e,
    output logic                    lcd_rs,
    output logic                    lcd_rw,
    output logic [7:0]              lcd_data
);

    logic                    digit_stb;
    logic [3:0]              digit;
    logic                    op_stb;
    op_t                     op;
    logic [value_w-1:0]      result;
    logic                    result_stb;
    logic [4*bcd_digits-1:0] bcd;
    logic                    negative;
    logic                    done;
    logic [3:0]              char_index;
    logic [7:0]              char;

    key_decoder key_decoder_inst (
        .rst       (rst),
        .clk_100hz (clk_100hz),
        .swp       (swp),
        .swd       (swd),
        .digit_stb (digit_stb),
        .digit     (digit),
        .op_stb    (op_stb),
        .op        (op)
    );

    calc_datapath calc_datapath_inst (
        .rst        (rst),
        .clk_100hz  (clk_100hz),
        .digit_stb  (digit_stb),
        .digit      (digit),
        .op_stb     (op_stb),
        .op         (op),
        .result     (result),
        .result_stb (result_stb)
    );

    bin_to_bcd bin_to_bcd_inst (
        .rst        (rst),
        .clk_100hz  (clk_100hz),
        .result     (result),
        .result_stb (result_stb),
        .bcd        (bcd),
        .negative   (negative),
        .done       (done)
    );

    result_line result_line_inst (
        .rst        (rst),
        .clk_100hz  (clk_100hz),
        .bcd        (bcd),
        .negative   (negative),
        .done       (done),
        .char_index (char_index),
        .char       (char)
    );

    lcd_controller lcd_controller_inst (
        .rst        (rst),
        .clk_100hz  (clk_100hz),
        .char_index (char_index),
        .char       (char),
        .lcd_e      (lcd_e),
        .lcd_rs     (lcd_rs),
        .lcd_rw     (lcd_rw),
        .lcd_data   (lcd_data)
    );

endmodule

`default_nettype wire

/* hw/lcd_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module lcd_controller import calc_pkg::*; (
    input  logic       rst,
    input  logic       clk_100hz,
    output logic [3:0] char_index,
    input  logic [7:0] char,
    output logic       lcd_e,
    output logic       lcd_rs,
    output logic       lcd_rw,
    output logic [7:0] lcd_data
);

    logic [lcd_state_w-1:0] state;
    logic [15:0]            hold_cnt;
    logic [15:0]            hold_len;
    logic                   hold_last;
    logic                   in_write;
    logic                   wr_rs;
    logic [7:0]             wr_data;

    // bus value and duration of the current state
    always_comb
    begin
        in_write = 1'b1;
        wr_rs    = 1'b0;
        wr_data  = 8'h00;
        hold_len = t_cmd_hold;
        case (state)
            st_func:  wr_data = cmd_function_set;
            st_disp:  wr_data = cmd_display_on;
            st_entry: wr_data = cmd_entry_mode;
            st_addr:  wr_data = cmd_line2_addr;
            st_char:
            begin
                wr_rs   = 1'b1;
                wr_data = char;
            end
            st_gap:
            begin
                in_write = 1'b0;
                hold_len = t_refresh_gap;
            end
            default:
            begin
                in_write = 1'b0;
                hold_len = t_power_up;
            end
        endcase
    end

    assign hold_last = (hold_cnt == hold_len - 16'd1);

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            state      <= st_power_up;
            hold_cnt   <= '0;
            char_index <= '0;
        end
        else if (hold_last)
        begin
            hold_cnt <= '0;
            case (state)
                st_power_up: state <= st_func;
                st_func:     state <= st_disp;
                st_disp:     state <= st_entry;
                st_entry:    state <= st_addr;
                st_addr:     state <= st_char;
                st_char:
                begin
                    // index wraps back to 0 after the last column
                    char_index <= char_index + 4'd1;
                    if (char_index == 4'(line_len - 1))
                        state <= st_gap;
                end
                default:     state <= st_addr;
            endcase
        end
        else
        begin
            hold_cnt <= hold_cnt + 16'd1;
        end
    end

    // bus loads once per write, enable pulses mid-hold
    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            lcd_e    <= 1'b0;
            lcd_rs   <= 1'b1;
            lcd_rw   <= 1'b1;
            lcd_data <= 8'h00;
        end
        else
        begin
            lcd_e <= in_write && (hold_cnt == t_cmd_hold / 2);
            if (in_write && hold_cnt == 16'd0)
            begin
                lcd_rs   <= wr_rs;
                lcd_rw   <= 1'b0;
                lcd_data <= wr_data;
            end
        end
    end

    a_data_stable: assert property (@(posedge rst) disable iff (clk_100hz)
        lcd_e |-> $stable(lcd_data) ##1 $stable(lcd_data));

endmodule

`default_nettype wire

/* hw/result_line.sv */
`timescale 1ns/100ps
`default_nettype none

module result_line import calc_pkg::*; (
    input  logic                    rst,
    input  logic                    clk_100hz,
    input  logic [4*bcd_digits-1:0] bcd,
    input  logic                    negative,
    input  logic                    done,
    input  logic [3:0]              char_index,
    output logic [7:0]              char
);

    logic [7:0] line_buf [line_len];
    logic [7:0] line_next [line_len];

    always_comb
    begin
        int msd;
        int pos;
        // highest nonzero digit, digit 0 stays visible for a zero result
        msd = 0;
        for (int i = 0; i < bcd_digits; i++)
        begin
            if (bcd[4*i +: 4] != 4'd0)
                msd = i;
        end
        for (int c = 0; c < line_len; c++)
        begin
            // digit index shown in this column, right aligned
            pos = line_len - 1 - c;
            if (pos <= msd)
                line_next[c] = ascii_0 + {4'h0, bcd[4*pos +: 4]};
            else if (negative && pos == msd + 1)
                line_next[c] = ascii_minus;
            else
                line_next[c] = ascii_blank;
        end
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            for (int c = 0; c < line_len; c++)
                line_buf[c] <= ascii_blank;
        end
        else if (done)
        begin
            line_buf <= line_next;
        end
    end

    assign char = line_buf[char_index];

endmodule

`default_nettype wire

/* hw/bin_to_bcd.sv */
`timescale 1ns/100ps
`default_nettype none

module bin_to_bcd import calc_pkg::*; (
    input  logic                    rst,
    input  logic                    clk_100hz,
    input  logic [value_w-1:0]      result,
    input  logic                    result_stb,
    output logic [4*bcd_digits-1:0] bcd,
    output logic                    negative,
    output logic                    done
);

    logic [value_w-1:0]         mag;
    logic [4*bcd_digits-1:0]    bcd_adj;
    logic [$clog2(value_w)-1:0] step;
    logic                       busy;
    logic                       last_step;

    // add 3 to every digit of 5 or more before the shift
    always_comb
    begin
        for (int i = 0; i < bcd_digits; i++)
        begin
            if (bcd[4*i +: 4] >= 4'd5)
                bcd_adj[4*i +: 4] = bcd[4*i +: 4] + 4'd3;
            else
                bcd_adj[4*i +: 4] = bcd[4*i +: 4];
        end
    end

    assign last_step = (int'(step) == value_w - 1);

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            busy <= 1'b0;
            step <= '0;
            done <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (result_stb)
            begin
                busy <= 1'b1;
                step <= '0;
            end
            else if (busy)
            begin
                step <= step + 1'b1;
                if (last_step)
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // sign and magnitude, the most negative value still fits unsigned
    always_ff @(posedge rst)
    begin
        if (result_stb)
        begin
            negative <= result[value_w-1];
            mag      <= result[value_w-1] ? -result : result;
            bcd      <= '0;
        end
        else if (busy)
        begin
            bcd <= {bcd_adj[4*bcd_digits-2:0], mag[value_w-1]};
            mag <= mag << 1;
        end
    end

    a_no_restart: assert property (@(posedge rst) disable iff (clk_100hz)
        result_stb |-> !busy);

endmodule

`default_nettype wire

/* hw/calc_datapath.sv */
`timescale 1ns/100ps
`default_nettype none

module calc_datapath import calc_pkg::*; (
    input  logic               rst,
    input  logic               clk_100hz,
    input  logic               digit_stb,
    input  logic [3:0]         digit,
    input  logic               op_stb,
    input  op_t                op,
    output logic [value_w-1:0] result,
    output logic               result_stb
);

    logic [value_w-1:0] term;
    logic [value_w-1:0] acc;
    op_t                pend;
    logic [value_w-1:0] acc_next;
    logic               is_equ;

    // pending operation on accumulator and term, all wrapping
    always_comb
    begin
        case (pend)
            op_sub:  acc_next = acc - term;
            op_mul:  acc_next = acc * term;
            default: acc_next = acc + term;
        endcase
    end

    assign is_equ = (op == op_equ);

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            term       <= '0;
            acc        <= '0;
            pend       <= op_add;
            result_stb <= 1'b0;
        end
        else
        begin
            result_stb <= 1'b0;
            if (digit_stb)
            begin
                term <= term * 10 + value_w'(digit);
            end
            else if (op_stb)
            begin
                acc        <= acc_next;
                term       <= '0;
                // equals leaves the result as the first operand of an add
                pend       <= is_equ ? op_add : op;
                result_stb <= is_equ;
            end
        end
    end

    always_ff @(posedge rst)
    begin
        if (op_stb && is_equ)
            result <= acc_next;
    end

endmodule

`default_nettype wire

/* hw/key_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module key_decoder import calc_pkg::*; (
    input  logic                    rst,
    input  logic                    clk_100hz,
    input  logic [digit_keys_w-1:0] swp,
    input  logic [op_keys_w-1:0]    swd,
    output logic                    digit_stb,
    output logic [3:0]              digit,
    output logic                    op_stb,
    output op_t                     op
);

    logic [digit_keys_w-1:0] swp_q;
    logic [digit_keys_w-1:0] swp_prev;
    logic [op_keys_w-1:0]    swd_q;
    logic [op_keys_w-1:0]    swd_prev;
    logic                    digit_hit;
    logic [3:0]              digit_code;
    logic                    op_hit;
    op_t                     op_code;
    logic                    digit_edge;
    logic                    op_edge;

    // map the pad bit back to its digit value
    always_comb
    begin
        digit_hit  = 1'b0;
        digit_code = 4'd0;
        for (int d = 0; d < $size(digit_key_bit); d++)
        begin
            if (swp_q[digit_key_bit[d]])
            begin
                digit_hit  = 1'b1;
                digit_code = 4'(d);
            end
        end
    end

    always_comb
    begin
        if (swd_q[op_bit_add])
            op_code = op_add;
        else if (swd_q[op_bit_sub])
            op_code = op_sub;
        else if (swd_q[op_bit_mul])
            op_code = op_mul;
        else
            op_code = op_equ;
    end

    assign op_hit = swd_q[op_bit_add] | swd_q[op_bit_sub] | swd_q[op_bit_mul] |
                    swd_q[op_bit_equ];

    // a new valid one-hot code counts as a press
    assign digit_edge = $onehot(swp_q) && digit_hit && (swp_q != swp_prev);
    assign op_edge    = $onehot(swd_q) && op_hit && (swd_q != swd_prev);

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            swp_q     <= '0;
            swp_prev  <= '0;
            swd_q     <= '0;
            swd_prev  <= '0;
            digit_stb <= 1'b0;
            op_stb    <= 1'b0;
        end
        else
        begin
            swp_q     <= swp;
            swp_prev  <= swp_q;
            swd_q     <= swd;
            swd_prev  <= swd_q;
            digit_stb <= digit_edge;
            // digit has priority, the operator press is lost
            op_stb    <= op_edge && !digit_edge;
        end
    end

    always_ff @(posedge rst)
    begin
        if (digit_edge)
            digit <= digit_code;
        if (op_edge)
            op <= op_code;
    end

    a_one_strobe: assert property (@(posedge rst) disable iff (clk_100hz)
        !(digit_stb && op_stb));

endmodule

`default_nettype wire

/* hw/calc_pkg.sv */
`default_nettype none

package calc_pkg;

    // switch bank widths
    localparam int digit_keys_w = 12;
    localparam int op_keys_w    = 8;

    // pad bit of each digit, indexed by digit value
    localparam logic [3:0] digit_key_bit [10] = '{
        4'd1, 4'd11, 4'd10, 4'd9, 4'd8, 4'd7, 4'd6, 4'd5, 4'd4, 4'd3
    };

    // operator switch bits
    localparam int op_bit_add = 7;
    localparam int op_bit_sub = 6;
    localparam int op_bit_mul = 5;
    localparam int op_bit_equ = 0;

    typedef logic [1:0] op_t;

    localparam op_t op_add = 2'd0;
    localparam op_t op_sub = 2'd1;
    localparam op_t op_mul = 2'd2;
    localparam op_t op_equ = 2'd3;

    localparam int value_w    = 32;
    localparam int bcd_digits = 10;
    localparam int line_len   = 16;

    localparam logic [7:0] ascii_0     = 8'h30;
    localparam logic [7:0] ascii_blank = 8'h20;
    localparam logic [7:0] ascii_minus = 8'h2D;

    // hd44780 style command bytes
    localparam logic [7:0] cmd_function_set = 8'h3C;
    localparam logic [7:0] cmd_display_on   = 8'h0C;
    localparam logic [7:0] cmd_entry_mode   = 8'h06;
    localparam logic [7:0] cmd_line2_addr   = 8'hC0;

    // sequencer timing in clock cycles
    localparam logic [15:0] t_power_up    = 16'd40;
    localparam logic [15:0] t_cmd_hold    = 16'd8;
    localparam logic [15:0] t_refresh_gap = 16'd64;

    // lcd sequencer states
    localparam int lcd_state_w = 3;

    localparam logic [lcd_state_w-1:0] st_power_up = 3'd0;
    localparam logic [lcd_state_w-1:0] st_func     = 3'd1;
    localparam logic [lcd_state_w-1:0] st_disp     = 3'd2;
    localparam logic [lcd_state_w-1:0] st_entry    = 3'd3;
    localparam logic [lcd_state_w-1:0] st_addr     = 3'd4;
    localparam logic [lcd_state_w-1:0] st_char     = 3'd5;
    localparam logic [lcd_state_w-1:0] st_gap      = 3'd6;

endpackage

`default_nettype wire
